//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_asym_tx_buffer \
   --Mdir obj_dir -o sim_tb \
   -f verilog.f

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"

//--- src/asym_tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module asym_tx_buffer
   import axil_pkg::*, buf_types_pkg::*;
#(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 10
) (
   input  wire logic      r_clk,
   input  wire logic      rst,
   input  wire axil_req_t axil_req,
   output axil_rsp_t      axil_rsp,
   output stream_beat_t   out_beat,
   output logic           out_valid,
   input  wire logic      out_ready
);

   // word index width on the wide side
   localparam int WORD_ADDR_W = ADDR_W - $clog2(W_DATA_W / R_DATA_W);

   logic                   w_en;
   logic [WORD_ADDR_W-1:0] w_addr;
   logic [W_DATA_W-1:0]    w_data;
   logic                   start;
   logic [10:0]            length;
   logic                   busy;
   logic [10:0]            bytes_sent;
   logic                   r_en;
   logic [ADDR_W-1:0]      r_addr;
   logic [R_DATA_W-1:0]    r_data;

   axil_buf_regs u_axil_buf_regs (
      .r_clk      (r_clk),
      .rst        (rst),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .w_en       (w_en),
      .w_addr     (w_addr),
      .w_data     (w_data),
      .start      (start),
      .length     (length),
      .busy       (busy),
      .bytes_sent (bytes_sent)
   );

   ram_t2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram_t2p_asym (
      .r_clk  (r_clk),
      .w_en   (w_en),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (r_en),
      .r_addr (r_addr),
      .r_data (r_data)
   );

   byte_stream_reader u_byte_stream_reader (
      .r_clk      (r_clk),
      .rst        (rst),
      .start      (start),
      .length     (length),
      .r_en       (r_en),
      .r_addr     (r_addr),
      .r_data     (r_data),
      .out_beat   (out_beat),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .busy       (busy),
      .bytes_sent (bytes_sent)
   );

endmodule

`default_nettype wire

//--- src/axil_buf_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_buf_regs
   import axil_pkg::*, buf_types_pkg::*;
(
   input  wire logic        r_clk,
   input  wire logic        rst,
   input  wire axil_req_t   axil_req,
   output axil_rsp_t        axil_rsp,
   output logic             w_en,
   output logic [7:0]       w_addr,
   output logic [31:0]      w_data,
   output logic             start,
   output logic [10:0]      length,
   input  wire logic        busy,
   input  wire logic [10:0] bytes_sent
);

   logic        bvalid_q;
   logic [1:0]  bresp_q;
   logic        rvalid_q;
   logic [1:0]  rresp_q;
   logic [31:0] rdata_q;
   logic        start_q;
   buf_ctrl_u   ctrl_q;
   buf_ctrl_u   wr_word;
   logic [31:0] stat_word;

   logic        wr_hs;
   logic        rd_hs;
   logic        wr_buf;
   logic        wr_ctrl;

   assign wr_word.raw = axil_req.wdata;

   // aw and w are taken together, one write outstanding
   assign wr_hs   = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
   assign rd_hs   = axil_req.arvalid && !rvalid_q;
   assign wr_buf  = axil_req.awaddr[11:10] == BUF_WIN_BASE[11:10];
   assign wr_ctrl = axil_req.awaddr == CTRL_ADDR;

   // buffer writes are always full words
   assign w_en   = wr_hs && wr_buf;
   assign w_addr = axil_req.awaddr[9:2];
   assign w_data = axil_req.wdata;

   assign start  = start_q;
   assign length = ctrl_q.f.length;

   always_comb begin
      stat_word = '0;
      stat_word[STAT_BUSY_BIT] = busy;
      stat_word[STAT_SENT_MSB:STAT_SENT_LSB] = bytes_sent;
   end

   always_comb begin
      axil_rsp         = '0;
      axil_rsp.awready = wr_hs;
      axil_rsp.wready  = wr_hs;
      axil_rsp.bresp   = bresp_q;
      axil_rsp.bvalid  = bvalid_q;
      axil_rsp.arready = !rvalid_q;
      axil_rsp.rdata   = rdata_q;
      axil_rsp.rresp   = rresp_q;
      axil_rsp.rvalid  = rvalid_q;
   end

   always_ff @(posedge r_clk) begin
      if (rst) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
         start_q  <= 1'b0;
         ctrl_q   <= '0;
      end else begin
         // start pulse lines up with the new length in ctrl_q
         start_q <= wr_hs && wr_ctrl && wr_word.f.start;
         if (wr_hs && wr_ctrl) begin
            ctrl_q <= wr_word;
         end
         if (wr_hs) begin
            bvalid_q <= 1'b1;
         end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
         end
         if (rd_hs) begin
            rvalid_q <= 1'b1;
         end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // response payloads
   always_ff @(posedge r_clk) begin
      if (wr_hs) begin
         bresp_q <= (wr_buf || wr_ctrl) ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_hs) begin
         if (axil_req.araddr == STAT_ADDR) begin
            rdata_q <= stat_word;
            rresp_q <= RESP_OKAY;
         end else if (axil_req.araddr == CTRL_ADDR) begin
            rdata_q <= ctrl_q.raw;
            rresp_q <= RESP_OKAY;
         end else begin
            // buffer window is write only
            rdata_q <= '0;
            rresp_q <= RESP_SLVERR;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/axil_pkg.sv
`default_nettype none

package axil_pkg;

   // master to slave, all five channels
   typedef struct packed {
      logic [11:0] awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        wvalid;
      logic        bready;
      logic [11:0] araddr;
      logic        arvalid;
      logic        rready;
   } axil_req_t;

   // slave to master
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic [1:0]  bresp;
      logic        bvalid;
      logic        arready;
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic        rvalid;
   } axil_rsp_t;

   // bresp / rresp codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- src/buf_types_pkg.sv
`default_nettype none

package buf_types_pkg;

   // control word fields, length in the low bits
   typedef struct packed {
      logic [19:0] reserved;
      logic        start;
      logic [10:0] length;
   } buf_ctrl_t;

   // same control word, stored raw and read back as fields
   typedef union packed {
      logic [31:0] raw;
      buf_ctrl_t   f;
   } buf_ctrl_u;

   // one beat of the output byte stream
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } stream_beat_t;

   // register map
   localparam logic [11:0] BUF_WIN_BASE = 12'h000;
   localparam logic [11:0] CTRL_ADDR    = 12'h400;
   localparam logic [11:0] STAT_ADDR    = 12'h404;

   // status word layout
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_SENT_LSB = 16;
   localparam int STAT_SENT_MSB = 26;

endpackage

`default_nettype wire

//--- src/byte_stream_reader.sv
`timescale 1ns/1ps
`default_nettype none

module byte_stream_reader
   import buf_types_pkg::*;
(
   input  wire logic        r_clk,
   input  wire logic        rst,
   input  wire logic        start,
   input  wire logic [10:0] length,
   output logic             r_en,
   output logic [9:0]       r_addr,
   input  wire logic [7:0]  r_data,
   output stream_beat_t     out_beat,
   output logic             out_valid,
   input  wire logic        out_ready,
   output logic             busy,
   output logic [10:0]      bytes_sent
);

   logic         busy_q;
   logic [10:0]  len_q;
   logic [9:0]   rd_addr;
   logic [10:0]  rd_cnt;
   logic [10:0]  sent_cnt;
   logic         rd_pend;
   logic         pend_last;

   // two-entry beat queue
   stream_beat_t q_mem [2];
   logic         q_wr_ptr;
   logic         q_rd_ptr;
   logic [1:0]   q_cnt;

   logic         accept;
   logic         push;
   logic         pop;
   logic [2:0]   q_net;
   logic         issue;

   assign accept = start && !busy_q && (length != 11'd0);
   assign pop    = out_valid && out_ready;
   assign push   = rd_pend;

   // queue fill plus read in flight, less the beat leaving now
   assign q_net  = {1'b0, q_cnt} + {2'b00, rd_pend} - {2'b00, pop};
   assign issue  = busy_q && (rd_cnt != len_q) && (q_net < 3'd2);

   assign r_en       = issue;
   assign r_addr     = rd_addr;
   assign out_valid  = q_cnt != 2'd0;
   assign out_beat   = q_mem[q_rd_ptr];
   assign busy       = busy_q;
   assign bytes_sent = sent_cnt;

   always_ff @(posedge r_clk) begin
      if (rst) begin
         busy_q   <= 1'b0;
         rd_addr  <= '0;
         rd_cnt   <= '0;
         sent_cnt <= '0;
         rd_pend  <= 1'b0;
      end else begin
         rd_pend <= issue;
         if (accept) begin
            busy_q   <= 1'b1;
            rd_addr  <= '0;
            rd_cnt   <= '0;
            sent_cnt <= '0;
         end else begin
            if (issue) begin
               rd_addr <= rd_addr + 10'd1;
               rd_cnt  <= rd_cnt + 11'd1;
            end
            if (pop) begin
               sent_cnt <= sent_cnt + 11'd1;
               // transfer done once the final beat leaves
               if (out_beat.last) begin
                  busy_q <= 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge r_clk) begin
      if (rst) begin
         q_wr_ptr <= 1'b0;
         q_rd_ptr <= 1'b0;
         q_cnt    <= '0;
      end else begin
         if (push) begin
            q_wr_ptr <= !q_wr_ptr;
         end
         if (pop) begin
            q_rd_ptr <= !q_rd_ptr;
         end
         q_cnt <= q_cnt + 2'(push) - 2'(pop);
      end
   end

   always_ff @(posedge r_clk) begin
      if (accept) begin
         len_q <= length;
      end
      // last flag travels with the read
      if (issue) begin
         pend_last <= rd_cnt == (len_q - 11'd1);
      end
      if (push) begin
         q_mem[q_wr_ptr] <= '{data: r_data, last: pend_last};
      end
   end

endmodule

`default_nettype wire

//--- src/ram_t2p.sv
`timescale 1ns/1ps
`default_nettype none

module ram_t2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 8
) (
   input  wire logic              r_clk,
   input  wire logic              w_en,
   input  wire logic [ADDR_W-1:0] w_addr,
   input  wire logic [DATA_W-1:0] w_data,
   input  wire logic              r_en,
   input  wire logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0]      r_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output register holds its value between reads
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

//--- src/ram_t2p_asym.sv
`timescale 1ns/1ps
`default_nettype none

module ram_t2p_asym #(
   parameter  int W_DATA_W = 32,
   parameter  int R_DATA_W = 8,
   parameter  int ADDR_W   = 10,
   // lanes per wide word and the wide-side address width
   localparam int N_LANES  = W_DATA_W / R_DATA_W,
   localparam int LANE_W   = $clog2(N_LANES),
   localparam int W_ADDR_W = ADDR_W - LANE_W
) (
   input  wire logic                r_clk,
   input  wire logic                w_en,
   input  wire logic [W_ADDR_W-1:0] w_addr,
   input  wire logic [W_DATA_W-1:0] w_data,
   input  wire logic                r_en,
   input  wire logic [ADDR_W-1:0]   r_addr,
   output logic [R_DATA_W-1:0]      r_data
);

   // per-lane write data, lane i holds byte address 4*word + i
   logic [R_DATA_W-1:0] lane_w_data [N_LANES];
   logic [R_DATA_W-1:0] lane_r_data [N_LANES];

   // all lanes read the same word
   logic [W_ADDR_W-1:0] word_r_addr;
   logic [LANE_W-1:0]   lane_sel;

   // wide write goes to every lane at once
   always_comb begin
      for (int i = 0; i < N_LANES; i++) begin
         lane_w_data[i] = w_data[i*R_DATA_W +: R_DATA_W];
      end
   end

   assign word_r_addr = r_addr[ADDR_W-1:LANE_W];

   for (genvar i = 0; i < N_LANES; i++) begin : g_lane
      ram_t2p #(
         .DATA_W (R_DATA_W),
         .ADDR_W (W_ADDR_W)
      ) u_lane (
         .r_clk  (r_clk),
         .w_en   (w_en),
         .w_addr (w_addr),
         .w_data (lane_w_data[i]),
         .r_en   (r_en),
         .r_addr (word_r_addr),
         .r_data (lane_r_data[i])
      );
   end

   // lane select follows the lane outputs by one cycle
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         lane_sel <= r_addr[LANE_W-1:0];
      end
   end

   assign r_data = lane_r_data[lane_sel];

endmodule

`default_nettype wire

//--- tests/tb_asym_tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_asym_tx_buffer
   import axil_pkg::*, buf_types_pkg::*;
();

   localparam int LEN_STREAM = 256;
   localparam int LEN_BP     = 101;
   localparam int LEN_BUSY   = 200;
   localparam int WATCHDOG_CYCLES = (LEN_STREAM + LEN_BP + LEN_BUSY) * 20 + 2000;
   localparam int HS_TIMEOUT = 50;
   localparam int SEED       = 30;

   logic         r_clk = 1'b0;
   logic         rst;
   axil_req_t    axil_req;
   axil_rsp_t    axil_rsp;
   stream_beat_t out_beat;
   logic         out_valid;
   logic         out_ready = 1'b0;

   // byte image of the buffer indexed by byte address
   logic [7:0]   model_mem [1024];
   int           beat_cnt;
   int           xfer_base;
   int           cur_len;
   int           xfer_beats;
   logic [9:0]   exp_idx;
   logic [1:0]   exp_bresp;
   logic [1:0]   exp_rresp;
   logic         ready_rand;
   logic         ready_next;
   int           assert_fails;
   int           check_fails;
   int           fails_at_start;
   int           tests_run;
   int           tests_passed;
   string        test_name;

   asym_tx_buffer #(
      .W_DATA_W (32),
      .R_DATA_W (8),
      .ADDR_W   (10)
   ) u_asym_tx_buffer (
      .r_clk     (r_clk),
      .rst       (rst),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #4 r_clk = ~r_clk;

   // sink ready is held high or random
   always @(posedge r_clk) begin
      ready_next = ready_rand ? 1'($urandom % 2) : 1'b1;
      #1;
      out_ready = ready_next;
   end

   always @(posedge r_clk) begin
      if (rst) begin
         beat_cnt <= 0;
      end else if (out_valid && out_ready) begin
         beat_cnt <= beat_cnt + 1;
      end
   end

   assign xfer_beats = beat_cnt - xfer_base;
   assign exp_idx    = 10'(xfer_beats);

   a_beat_data: assert property (@(posedge r_clk) disable iff (rst)
      out_valid && out_ready |-> out_beat.data == model_mem[exp_idx])
   else begin
      assert_fails++;
      $display("[FAIL] %s beat %0d data: expected %h, actual %h",
               test_name, xfer_beats, model_mem[exp_idx], out_beat.data);
   end

   a_beat_last: assert property (@(posedge r_clk) disable iff (rst)
      out_valid && out_ready |-> out_beat.last == (xfer_beats == cur_len - 1))
   else begin
      assert_fails++;
      $display("[FAIL] %s beat %0d last: expected %0d, actual %0d",
               test_name, xfer_beats, xfer_beats == cur_len - 1, out_beat.last);
   end

   // stalled beat must not move
   a_beat_hold: assert property (@(posedge r_clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
   else begin
      assert_fails++;
      $display("%s: beat %0d changed or dropped while stalled", test_name, xfer_beats);
   end

   a_beat_count: assert property (@(posedge r_clk) disable iff (rst)
      out_valid |-> xfer_beats < cur_len)
   else begin
      assert_fails++;
      $display("%s: extra beat offered after %0d of %0d", test_name, xfer_beats, cur_len);
   end

   a_bresp: assert property (@(posedge r_clk) disable iff (rst)
      axil_rsp.bvalid && axil_req.bready |-> axil_rsp.bresp == exp_bresp)
   else begin
      assert_fails++;
      $display("[FAIL] %s bresp: expected %0d, actual %0d",
               test_name, exp_bresp, axil_rsp.bresp);
   end

   a_rresp: assert property (@(posedge r_clk) disable iff (rst)
      axil_rsp.rvalid && axil_req.rready |-> axil_rsp.rresp == exp_rresp)
   else begin
      assert_fails++;
      $display("[FAIL] %s rresp: expected %0d, actual %0d",
               test_name, exp_rresp, axil_rsp.rresp);
   end

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act == exp) else begin
         check_fails++;
         $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [1:0] exp);
      int n;
      exp_bresp        = exp;
      axil_req.awaddr  = addr;
      axil_req.wdata   = data;
      axil_req.wstrb   = 4'hf;
      axil_req.awvalid = 1'b1;
      axil_req.wvalid  = 1'b1;
      n = 0;
      @(negedge r_clk);
      while (!(axil_rsp.awready && axil_rsp.wready) && n < HS_TIMEOUT) begin
         @(negedge r_clk);
         n++;
      end
      @(posedge r_clk);
      #1;
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      if (n >= HS_TIMEOUT) begin
         check_fails++;
         $display("%s: write to %h was never accepted", test_name, addr);
      end
      n = 0;
      @(negedge r_clk);
      while (!axil_rsp.bvalid && n < HS_TIMEOUT) begin
         @(negedge r_clk);
         n++;
      end
      @(posedge r_clk);
      #1;
      if (n >= HS_TIMEOUT) begin
         check_fails++;
         $display("%s: no write response for %h", test_name, addr);
      end
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                            input logic [1:0] exp);
      int n;
      exp_rresp        = exp;
      axil_req.araddr  = addr;
      axil_req.arvalid = 1'b1;
      n = 0;
      @(negedge r_clk);
      while (!axil_rsp.arready && n < HS_TIMEOUT) begin
         @(negedge r_clk);
         n++;
      end
      @(posedge r_clk);
      #1;
      axil_req.arvalid = 1'b0;
      n = 0;
      @(negedge r_clk);
      while (!axil_rsp.rvalid && n < HS_TIMEOUT) begin
         @(negedge r_clk);
         n++;
      end
      data = axil_rsp.rdata;
      @(posedge r_clk);
      #1;
      if (n >= HS_TIMEOUT) begin
         check_fails++;
         $display("%s: no read response for %h", test_name, addr);
      end
   endtask

   // byte lane b of word i is byte 4*i + b
   task automatic load_word(input int idx, input logic [31:0] word);
      for (int b = 0; b < 4; b++) begin
         model_mem[10'(4 * idx + b)] = word[8*b +: 8];
      end
      axil_write(12'(4 * idx), word, RESP_OKAY);
   endtask

   task automatic write_ctrl(input int len, input logic start_bit);
      buf_ctrl_u ctrl;
      ctrl.raw      = '0;
      ctrl.f.length = 11'(len);
      ctrl.f.start  = start_bit;
      axil_write(CTRL_ADDR, ctrl.raw, RESP_OKAY);
   endtask

   task automatic start_xfer(input int len);
      xfer_base = beat_cnt;
      cur_len   = len;
      write_ctrl(len, 1'b1);
   endtask

   task automatic wait_xfer_done();
      int n;
      int limit;
      n = 0;
      limit = cur_len * 20 + 100;
      @(negedge r_clk);
      while (xfer_beats < cur_len && n < limit) begin
         @(negedge r_clk);
         n++;
      end
      @(posedge r_clk);
      #1;
      if (n >= limit) begin
         check_fails++;
         $display("%s: stream stopped after %0d of %0d beats", test_name, xfer_beats, cur_len);
      end
   endtask

   task automatic begin_test(input string name);
      test_name      = name;
      fails_at_start = assert_fails + check_fails;
   endtask

   task automatic end_test();
      int errs;
      errs = assert_fails + check_fails - fails_at_start;
      tests_run++;
      if (errs == 0) begin
         tests_passed++;
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, errs);
      end
   endtask

   initial begin
      logic [31:0] rd;
      void'($urandom(SEED));
      rst              = 1'b1;
      axil_req         = '0;
      axil_req.bready  = 1'b1;
      axil_req.rready  = 1'b1;
      ready_rand       = 1'b0;
      xfer_base        = 0;
      cur_len          = 0;
      exp_bresp        = RESP_OKAY;
      exp_rresp        = RESP_OKAY;
      assert_fails     = 0;
      check_fails      = 0;
      tests_run        = 0;
      tests_passed     = 0;
      test_name        = "reset";

      begin_test("reset");
      repeat (5) @(posedge r_clk);
      #1;
      check_value("out_valid in reset", 32'(0), 32'(out_valid));
      check_value("bvalid in reset", 32'(0), 32'(axil_rsp.bvalid));
      check_value("rvalid in reset", 32'(0), 32'(axil_rsp.rvalid));
      check_value("arready in reset", 32'(1), 32'(axil_rsp.arready));
      repeat (5) @(posedge r_clk);
      #1;
      rst = 1'b0;
      @(posedge r_clk);
      #1;
      check_value("out_valid after reset", 32'(0), 32'(out_valid));
      check_value("bvalid after reset", 32'(0), 32'(axil_rsp.bvalid));
      check_value("rvalid after reset", 32'(0), 32'(axil_rsp.rvalid));
      axil_read(STAT_ADDR, rd, RESP_OKAY);
      check_value("status after reset", 32'(0), rd);
      end_test();

      begin_test("load_stream");
      for (int i = 0; i < 64; i++) begin
         load_word(i, $urandom);
      end
      start_xfer(LEN_STREAM);
      wait_xfer_done();
      check_value("beats received", 32'(LEN_STREAM), 32'(xfer_beats));
      end_test();

      begin_test("back_pressure");
      ready_rand = 1'b1;
      start_xfer(LEN_BP);
      wait_xfer_done();
      ready_rand = 1'b0;
      check_value("beats received", 32'(LEN_BP), 32'(xfer_beats));
      end_test();

      begin_test("busy_ignore");
      start_xfer(LEN_BUSY);
      axil_read(STAT_ADDR, rd, RESP_OKAY);
      check_value("busy during transfer", 32'(1), 32'(rd[0]));
      // second start while busy must be dropped
      write_ctrl(50, 1'b1);
      wait_xfer_done();
      repeat (2) @(posedge r_clk);
      #1;
      axil_read(STAT_ADDR, rd, RESP_OKAY);
      check_value("status after transfer", 32'(LEN_BUSY << 16), rd);
      write_ctrl(0, 1'b1);
      repeat (20) @(posedge r_clk);
      #1;
      check_value("beats after empty start", 32'(LEN_BUSY), 32'(xfer_beats));
      end_test();

      begin_test("resp_codes");
      load_word(4, 32'h1234_5678);
      axil_write(STAT_ADDR, 32'h0000_0001, RESP_SLVERR);
      axil_write(12'h408, 32'h0, RESP_SLVERR);
      axil_write(12'h800, 32'h0, RESP_SLVERR);
      axil_write(12'hffc, 32'h0, RESP_SLVERR);
      // start bit clear so no transfer
      axil_write(CTRL_ADDR, 32'habc0_0123, RESP_OKAY);
      axil_read(CTRL_ADDR, rd, RESP_OKAY);
      check_value("ctrl readback", 32'habc0_0123, rd);
      axil_read(STAT_ADDR, rd, RESP_OKAY);
      axil_read(12'h010, rd, RESP_SLVERR);
      check_value("buffer read data", 32'h0, rd);
      axil_read(12'h408, rd, RESP_SLVERR);
      axil_read(12'hc00, rd, RESP_SLVERR);
      check_value("beats after ctrl writes", 32'(LEN_BUSY), 32'(xfer_beats));
      end_test();

      $display("tests: %0d run, %0d passed, %0d failed, %0d errors", tests_run,
               tests_passed, tests_run - tests_passed, assert_fails + check_fails);
      if (assert_fails + check_fails == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // bound on the whole run
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge r_clk);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
src/axil_pkg.sv
src/buf_types_pkg.sv
src/ram_t2p.sv
src/ram_t2p_asym.sv
src/axil_buf_regs.sv
src/byte_stream_reader.sv
src/asym_tx_buffer.sv
tests/tb_asym_tx_buffer.sv
